// File: common/videoTimingPkg.sv
//////////////////////////////////////////////////////////////////////
// scan timing constants for one 262-row field
// scan phase and video level enums, scan position struct
//////////////////////////////////////////////////////////////////////
`default_nettype none

package videoTimingPkg;

	// line lengths in clocks
	localparam int lineCycles = 6352;
	localparam int halfLineCycles = 3176;
	localparam int fieldRows = 262;

	// vertical interval half-line counts
	localparam int vSyncHalfLines = 5;
	localparam int eqHalfLinesEven = 6;
	localparam int eqHalfLinesOdd = 5;

	// horizontal windows, in clocks from line start
	localparam int burstStart = 112;
	localparam int burstEnd = 360;
	localparam int activeStart = 472;
	localparam int activeEnd = 5592;
	localparam int hSyncStart = 5880;
	localparam int vSyncLowStart = 472;
	localparam int eqLowStart = 2944;

	localparam int firstActiveRow = 20;
	localparam int blankLevel = 76;

	typedef enum logic [1:0] {vSync, eqPulse, scanLine} scanPhase_e;

	typedef enum logic [1:0] {levelSync, levelBlank, levelBurst, levelActive} videoLevel_e;

	// x counts half pixels, y counts visible rows
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} scanPos_t;

endpackage

`default_nettype wire

// File: common/cellFormatPkg.sv
//////////////////////////////////////////////////////////////////////
// 64-bit cell format: cell kind, colors, decoded cell
// host write port of the framebuffer
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cellFormatPkg;

	// top two bits of the first cell word
	typedef enum logic [1:0] {reservedA, reservedB, yuvPair, yuvdCentroid} cellKind_e;

	// final 8-bit pixel color
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] u;
		logic [7:0] v;
	} colorYuv_t;

	// 10-bit color before clamping
	// bit 9 flags underflow, bit 8 overflow
	typedef struct packed {
		logic [9:0] y;
		logic [9:0] u;
		logic [9:0] v;
	} colorWide_t;

	// endpoint colors plus sixteen 2-bit selectors
	// selector 0 in bits 31:30
	typedef struct packed {
		colorWide_t colorM;
		colorWide_t colorN;
		logic [31:0] bits;
	} cellColors_t;

	// one-cycle write strobe from the host
	// wordAddr bit 0 picks the second word of a cell
	typedef struct packed {
		logic enable;
		logic [13:0] wordAddr;
		logic [31:0] data;
	} fbWrite_t;

endpackage

`default_nettype wire

// File: timing/scanTiming.sv
//////////////////////////////////////////////////////////////////////
// pixel, row, half-line and field counters
// colorburst phase accumulator, registered level and position
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module scanTiming #(
	parameter int burstStep = 150137
) (
	input wire logic clock,
	input wire logic rst,
	output videoTimingPkg::scanPos_t scanPos,
	output videoTimingPkg::videoLevel_e level,
	output logic [4:0] burstPhase
);

	// rows past the 240 visible ones stay blank
	localparam int lastActiveRow = videoTimingPkg::firstActiveRow + 240;

	videoTimingPkg::scanPhase_e phase;
	logic [12:0] pixCount;
	logic [9:0] rowCount;
	logic [2:0] halfLeft;
	logic [2:0] eqCount;
	logic [1:0] fieldCount;
	logic [21:0] burstAcc;

	logic halfEnd;
	logic lineEnd;
	logic rowVisible;
	logic [1:0] nextField;
	videoTimingPkg::videoLevel_e levelNext;
	videoTimingPkg::scanPos_t posNext;

	assign halfEnd = pixCount == 13'(videoTimingPkg::halfLineCycles - 1);
	assign lineEnd = pixCount == 13'(videoTimingPkg::lineCycles - 1);
	assign nextField = fieldCount + 2'd1;
	assign rowVisible = (rowCount >= 10'(videoTimingPkg::firstActiveRow)) &&
		(rowCount < 10'(lastActiveRow));

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			phase <= videoTimingPkg::vSync;
			pixCount <= '0;
			rowCount <= '0;
			halfLeft <= 3'(videoTimingPkg::vSyncHalfLines);
			eqCount <= 3'(videoTimingPkg::eqHalfLinesEven);
			fieldCount <= '0;
			burstAcc <= '0;
		end
		else
		begin
			// subcarrier runs free within a field
			burstAcc <= burstAcc + 22'(burstStep);
			pixCount <= pixCount + 13'd1;
			case (phase)
				videoTimingPkg::vSync, videoTimingPkg::eqPulse:
				begin
					if (halfEnd)
					begin
						pixCount <= '0;
						if (halfLeft == 3'd1)
						begin
							// vsync hands over to the equalizing pulses
							phase <= (phase == videoTimingPkg::vSync) ?
								videoTimingPkg::eqPulse : videoTimingPkg::scanLine;
							halfLeft <= eqCount;
						end
						else
							halfLeft <= halfLeft - 3'd1;
					end
				end
				default:
				begin
					if (lineEnd)
					begin
						pixCount <= '0;
						if (rowCount == 10'(videoTimingPkg::fieldRows - 1))
						begin
							// field done, back to vsync
							rowCount <= '0;
							phase <= videoTimingPkg::vSync;
							halfLeft <= 3'(videoTimingPkg::vSyncHalfLines);
							fieldCount <= nextField;
							eqCount <= nextField[0] ? 3'(videoTimingPkg::eqHalfLinesOdd) :
								3'(videoTimingPkg::eqHalfLinesEven);
							// new field starts at phase field*8
							burstAcc <= {nextField, 20'd0};
						end
						else
							rowCount <= rowCount + 10'd1;
					end
				end
			endcase
		end
	end

	// region of the current counter value
	always_comb
	begin
		levelNext = videoTimingPkg::levelBlank;
		posNext = '0;
		case (phase)
			videoTimingPkg::vSync:
				if (pixCount >= 13'(videoTimingPkg::vSyncLowStart))
					levelNext = videoTimingPkg::levelSync;
			videoTimingPkg::eqPulse:
				if (pixCount >= 13'(videoTimingPkg::eqLowStart))
					levelNext = videoTimingPkg::levelSync;
			default:
			begin
				if (pixCount >= 13'(videoTimingPkg::hSyncStart))
					levelNext = videoTimingPkg::levelSync;
				else if ((pixCount >= 13'(videoTimingPkg::burstStart)) &&
					(pixCount < 13'(videoTimingPkg::burstEnd)))
					levelNext = videoTimingPkg::levelBurst;
				else if ((pixCount >= 13'(videoTimingPkg::activeStart)) &&
					(pixCount < 13'(videoTimingPkg::activeEnd)) && rowVisible)
				begin
					levelNext = videoTimingPkg::levelActive;
					// eight clocks per half pixel
					posNext.x = pixCount[12:3] - 10'(videoTimingPkg::activeStart / 8);
					posNext.y = rowCount - 10'(videoTimingPkg::firstActiveRow);
				end
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			level <= videoTimingPkg::levelBlank;
			scanPos <= '0;
			burstPhase <= '0;
		end
		else
		begin
			level <= levelNext;
			scanPos <= posNext;
			burstPhase <= burstAcc[21:17];
		end
	end

endmodule

`default_nettype wire

// File: cell/frameStore.sv
//////////////////////////////////////////////////////////////////////
// video memory, two banks of cell words
// host write port and cell fetch from the scan position
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module frameStore #(
	parameter int fbWords = 9600
) (
	input wire logic clock,
	input wire cellFormatPkg::fbWrite_t fbWrite,
	input wire videoTimingPkg::scanPos_t scanPos,
	output logic [31:0] cellLo,
	output logic [31:0] cellHi,
	output logic [3:0] subPixel
);

	localparam int bankDepth = fbWords / 2;
	localparam int idxBits = $clog2(bankDepth);
	localparam int cellsPerRow = 80;

	// first and second word of each cell
	logic [31:0] bankLo [bankDepth];
	logic [31:0] bankHi [bankDepth];

	logic [15:0] cellIdxWide;
	logic [idxBits-1:0] cellIdx;
	logic [3:0] subIdx;

	// 4x4 cells, x counts half pixels
	assign cellIdxWide = 16'(scanPos.y[9:2]) * 16'(cellsPerRow) + 16'(scanPos.x[9:3]);

	// host writes go straight in
	always_ff @(posedge clock)
	begin
		if (fbWrite.enable)
		begin
			if (fbWrite.wordAddr[0])
				bankHi[fbWrite.wordAddr[idxBits:1]] <= fbWrite.data;
			else
				bankLo[fbWrite.wordAddr[idxBits:1]] <= fbWrite.data;
		end
	end

	// index stage, then both words read together
	always_ff @(posedge clock)
	begin
		cellIdx <= cellIdxWide[idxBits-1:0];
		subIdx <= {scanPos.y[1:0], scanPos.x[2:1]};
		cellLo <= bankLo[cellIdx];
		cellHi <= bankHi[cellIdx];
		subPixel <= subIdx;
	end

endmodule

`default_nettype wire

// File: cell/cellDecode.sv
//////////////////////////////////////////////////////////////////////
// cell kind decode into endpoint colors and selectors
// selector pick, clamp and blend, registered pixel color
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module cellDecode (
	input wire logic clock,
	input wire logic rst,
	input wire logic [31:0] cellLo,
	input wire logic [31:0] cellHi,
	input wire logic [3:0] subPixel,
	output cellFormatPkg::colorYuv_t pixel
);

	cellFormatPkg::cellKind_e kind;
	cellFormatPkg::cellColors_t decoded;
	cellFormatPkg::cellColors_t colors;
	logic [3:0] subDelay;
	logic [9:0] centerLuma;
	logic [9:0] deltaLuma;
	logic [9:0] lumaM;
	logic [31:0] selWide;
	logic [1:0] sel;
	cellFormatPkg::colorYuv_t colorM8;
	cellFormatPkg::colorYuv_t colorN8;
	cellFormatPkg::colorYuv_t pixelNext;

	// negative goes to 0, above 255 saturates
	function automatic logic [7:0] clampComp(input logic [9:0] c);
		if (c[9])
			return 8'd0;
		else if (c[8])
			return 8'hff;
		return c[7:0];
	endfunction

	function automatic cellFormatPkg::colorYuv_t clampColor(input cellFormatPkg::colorWide_t c);
		cellFormatPkg::colorYuv_t r;
		r.y = clampComp(c.y);
		r.u = clampComp(c.u);
		r.v = clampComp(c.v);
		return r;
	endfunction

	// three quarters a, one quarter b, each term floored
	function automatic cellFormatPkg::colorYuv_t mixColor(input cellFormatPkg::colorYuv_t a,
		input cellFormatPkg::colorYuv_t b);
		cellFormatPkg::colorYuv_t r;
		r.y = (a.y >> 1) + (a.y >> 2) + (b.y >> 2);
		r.u = (a.u >> 1) + (a.u >> 2) + (b.u >> 2);
		r.v = (a.v >> 1) + (a.v >> 2) + (b.v >> 2);
		return r;
	endfunction

	assign kind = cellFormatPkg::cellKind_e'(cellLo[31:30]);
	assign centerLuma = {2'b00, cellLo[15:8]};
	assign deltaLuma = {2'b00, cellLo[7:0]};
	// may wrap negative, caught by the clamp
	assign lumaM = centerLuma - (deltaLuma >> 1);

	always_comb
	begin
		// reserved kinds keep the previous colors
		decoded = colors;
		decoded.bits = '0;
		case (kind)
			cellFormatPkg::yuvPair:
			begin
				// 7-bit lumas, top bit repeated below
				decoded.colorM.y = {2'b00, cellLo[29:23], cellLo[29]};
				decoded.colorN.y = {2'b00, cellLo[22:16], cellLo[22]};
				decoded.colorM.u = {2'b00, cellLo[15:12], 4'h0};
				decoded.colorM.v = {2'b00, cellLo[11:8], 4'h0};
				decoded.colorN.u = {2'b00, cellLo[7:4], 4'h0};
				decoded.colorN.v = {2'b00, cellLo[3:0], 4'h0};
				decoded.bits = cellHi;
			end
			cellFormatPkg::yuvdCentroid:
			begin
				// shared chroma, lumas spread around the center
				decoded.colorM.y = lumaM;
				decoded.colorN.y = lumaM + deltaLuma;
				decoded.colorM.u = {2'b00, cellLo[29:23], 1'b0};
				decoded.colorM.v = {2'b00, cellLo[22:16], 1'b0};
				decoded.colorN.u = {2'b00, cellLo[29:23], 1'b0};
				decoded.colorN.v = {2'b00, cellLo[22:16], 1'b0};
				decoded.bits = cellHi;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			colors <= '0;
			subDelay <= '0;
		end
		else
		begin
			colors <= decoded;
			subDelay <= subPixel;
		end
	end

	// selector for this sub-pixel lands in the top pair
	assign selWide = colors.bits << {subDelay, 1'b0};
	assign sel = selWide[31:30];
	assign colorM8 = clampColor(colors.colorM);
	assign colorN8 = clampColor(colors.colorN);

	always_comb
	begin
		case (sel)
			2'd0: pixelNext = colorM8;
			2'd1: pixelNext = colorN8;
			2'd2: pixelNext = mixColor(colorM8, colorN8);
			default: pixelNext = mixColor(colorN8, colorM8);
		endcase
	end

	always_ff @(posedge clock)
	begin
		pixel <= pixelNext;
	end

endmodule

`default_nettype wire

// File: logic/compositeEncoder.sv
//////////////////////////////////////////////////////////////////////
// composite encoder: subcarrier sine table, chroma modulation
// level selection and 4-bit dithered PWM output
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module compositeEncoder (
	input wire logic clock,
	input wire logic rst,
	input wire videoTimingPkg::videoLevel_e level,
	input wire logic [4:0] burstPhase,
	input wire cellFormatPkg::colorYuv_t pixel,
	output logic [3:0] pwmOut
);

	// level and phase wait out the cell pipeline
	localparam int alignDepth = 4;

	// one subcarrier period, centered on 128
	localparam logic [7:0] sineTab [32] = '{
		8'h80, 8'h87, 8'h8e, 8'h94, 8'h9a, 8'h9e, 8'ha2, 8'ha4,
		8'ha5, 8'ha4, 8'ha2, 8'h9e, 8'h9a, 8'h94, 8'h8e, 8'h87,
		8'h80, 8'h79, 8'h72, 8'h6c, 8'h66, 8'h62, 8'h5e, 8'h5c,
		8'h5b, 8'h5c, 8'h5e, 8'h62, 8'h66, 8'h6c, 8'h72, 8'h79
	};

	videoTimingPkg::videoLevel_e levelPipe [alignDepth];
	logic [4:0] phasePipe [alignDepth];
	videoTimingPkg::videoLevel_e levelAligned;
	logic [4:0] phaseAligned;
	logic [4:0] phaseU;
	logic [4:0] phaseV;
	logic signed [8:0] modU;
	logic signed [8:0] modV;
	logic signed [8:0] baseU;
	logic signed [8:0] baseV;
	logic signed [17:0] prodU;
	logic signed [17:0] prodV;
	logic [15:0] lumaTerm;
	logic [9:0] activeSum;
	logic [7:0] valueNext;
	logic [7:0] value;
	logic [3:0] ditherAcc;
	logic [4:0] ditherSum;

	assign levelAligned = levelPipe[alignDepth-1];
	assign phaseAligned = phasePipe[alignDepth-1];

	// u and v carriers sit at fixed offsets from the burst
	assign phaseU = phaseAligned + 5'd11;
	assign phaseV = phaseAligned + 5'd3;
	assign modU = $signed({1'b0, sineTab[phaseU]}) - 9'sd128;
	assign modV = $signed({1'b0, sineTab[phaseV]}) - 9'sd128;
	assign baseU = $signed({1'b0, pixel.u}) - 9'sd128;
	assign baseV = $signed({1'b0, pixel.v}) - 9'sd128;
	assign prodU = modU * baseU;
	assign prodV = modV * baseV;

	// luma scaled above blanking
	assign lumaTerm = 16'(pixel.y) * 16'd144 + 16'd19456;
	assign activeSum = {2'b00, lumaTerm[15:8]} + prodU[15:6] + prodV[15:6];

	always_comb
	begin
		case (levelAligned)
			videoTimingPkg::levelSync: valueNext = 8'd0;
			videoTimingPkg::levelBurst: valueNext = sineTab[phaseAligned] - 8'd32;
			videoTimingPkg::levelActive: valueNext = activeSum[7:0];
			default: valueNext = 8'(videoTimingPkg::blankLevel);
		endcase
	end

	// low nibble feeds the dither accumulator
	assign ditherSum = {1'b0, ditherAcc} + {1'b0, value[3:0]};
	assign pwmOut = (ditherSum[4] && (value[7:4] != 4'hf)) ? value[7:4] + 4'd1 : value[7:4];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < alignDepth; i++)
			begin
				levelPipe[i] <= videoTimingPkg::levelSync;
				phasePipe[i] <= '0;
			end
			value <= '0;
			ditherAcc <= '0;
		end
		else
		begin
			levelPipe[0] <= level;
			phasePipe[0] <= burstPhase;
			for (int i = 1; i < alignDepth; i++)
			begin
				levelPipe[i] <= levelPipe[i-1];
				phasePipe[i] <= phasePipe[i-1];
			end
			value <= valueNext;
			ditherAcc <= ditherSum[3:0];
		end
	end

endmodule

`default_nettype wire

// File: logic/fbNtsc.sv
//////////////////////////////////////////////////////////////////////
// composite video generator top level
// scan timing, frame store, cell decode, composite encoder
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fbNtsc #(
	parameter int fbWords = 9600,
	parameter int burstStep = 150137
) (
	input wire logic clock,
	input wire logic rst,
	input wire cellFormatPkg::fbWrite_t fbWrite,
	output logic [3:0] pwmOut
);

	// scan position and region from the timing block
	videoTimingPkg::scanPos_t scanPos;
	videoTimingPkg::videoLevel_e level;
	logic [4:0] burstPhase;

	// fetched cell and sub-pixel index
	logic [31:0] cellLo;
	logic [31:0] cellHi;
	logic [3:0] subPixel;

	// decoded pixel color
	cellFormatPkg::colorYuv_t pixel;

	scanTiming #(.burstStep(burstStep)) u_scanTiming (
		.clock(clock),
		.rst(rst),
		.scanPos(scanPos),
		.level(level),
		.burstPhase(burstPhase)
	);

	frameStore #(.fbWords(fbWords)) u_frameStore (
		.clock(clock),
		.fbWrite(fbWrite),
		.scanPos(scanPos),
		.cellLo(cellLo),
		.cellHi(cellHi),
		.subPixel(subPixel)
	);

	cellDecode u_cellDecode (
		.clock(clock),
		.rst(rst),
		.cellLo(cellLo),
		.cellHi(cellHi),
		.subPixel(subPixel),
		.pixel(pixel)
	);

	// level path is delayed inside to meet the pixel
	compositeEncoder u_compositeEncoder (
		.clock(clock),
		.rst(rst),
		.level(level),
		.burstPhase(burstPhase),
		.pixel(pixel),
		.pwmOut(pwmOut)
	);

endmodule

`default_nettype wire

// File: dv/fbNtsc_assert.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks bound into the composite encoder
// sync and blanking levels, dither range of pwmOut
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fbNtscAssert (
	input wire logic clock,
	input wire logic rst,
	input wire videoTimingPkg::videoLevel_e levelAligned,
	input wire logic [7:0] value,
	input wire logic [3:0] pwmOut
);

	// 76 sits between dither levels 4 and 5
	localparam logic [3:0] blankNibble = 4'(videoTimingPkg::blankLevel / 16);

	// value register follows the aligned level one clock later
	syncZero: assert property (@(posedge clock) disable iff (rst)
		($past(levelAligned) == videoTimingPkg::levelSync) |-> (value == 8'd0))
		else $error("value %h after sync level", value);

	// steady blanking dithers between two levels only
	blankSteady: assert property (@(posedge clock) disable iff (rst)
		($past(levelAligned) == videoTimingPkg::levelBlank) |->
		((pwmOut == blankNibble) || (pwmOut == blankNibble + 4'd1)))
		else $error("pwmOut %h during blanking", pwmOut);

	// top nibble 15 must not wrap to 0
	noWrap: assert property (@(posedge clock) disable iff (rst)
		(value[7:4] == 4'hf) |-> (pwmOut == 4'hf))
		else $error("pwmOut %h wrapped, value %h", pwmOut, value);

endmodule

`default_nettype wire

// File: dv/fbNtscTb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the composite video generator
// clock and reset, framebuffer fills, mirrored scan counters
// per-test checks on pwmOut, timeout and summary
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fbNtscTb;

	localparam int fbWords = 9600;
	localparam int cellCount = fbWords / 2;
	localparam int cellsPerRow = 80;
	// timing reg, four stages to the color, encoder reg
	localparam int pipeDelay = 6;
	// extremes of the subcarrier table
	localparam int sineMin = 91;
	localparam int sineMax = 165;
	localparam int blankLo = videoTimingPkg::blankLevel / 16;
	localparam int blankHi = blankLo + 1;
	localparam int burstLo = (sineMin - 32) / 16;
	localparam int burstHi = (sineMax - 32) / 16 + 1;
	localparam int errShown = 20;
	// two fields with 6 then 5 eq half-lines, both fills, a sixth spare
	localparam int fieldBase = videoTimingPkg::fieldRows * videoTimingPkg::lineCycles;
	localparam int runCycles = 2 * fieldBase + 2 * fbWords + 10 +
		(2 * videoTimingPkg::vSyncHalfLines + videoTimingPkg::eqHalfLinesEven +
		videoTimingPkg::eqHalfLinesOdd) * videoTimingPkg::halfLineCycles;
	localparam int cycleLimit = runCycles + runCycles / 6;

	logic clock;
	logic rst;
	cellFormatPkg::fbWrite_t fbWrite;
	logic [3:0] pwmOut;

	// mirrored scan state
	videoTimingPkg::scanPhase_e scanPhase;
	int scanPix;
	int scanRow;
	int halfLeft;
	int eqCount;
	int fieldNum;

	int cycles;
	int fillMode;
	logic [31:0] rngState;
	int lumaM [cellCount];
	int lumaN [cellCount];
	int checks [6];
	int fails [6];
	string testName [6] = '{"sync tips", "blanking", "colorburst", "yuvd gray",
		"yuv pair", "second field"};

	fbNtsc u_dut (
		.clock(clock),
		.rst(rst),
		.fbWrite(fbWrite),
		.pwmOut(pwmOut)
	);

	bind compositeEncoder fbNtscAssert u_assert (
		.clock(clock),
		.rst(rst),
		.levelAligned(levelAligned),
		.value(value),
		.pwmOut(pwmOut)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// 8-bit level for a gray pixel of this luma
	function automatic int levelValue(input int luma);
		return (144 * luma + 19456) / 256;
	endfunction

	function automatic bit pwmFits(input int pw, input int lumaLo, input int lumaHi);
		return (pw >= levelValue(lumaLo) / 16) && (pw <= levelValue(lumaHi) / 16 + 1);
	endfunction

	// first field counts toward its own test, the next one toward test 6
	function automatic int timingTest(input int base);
		return (fieldNum == 0) ? base : 5;
	endfunction

	always #50 clock = ~clock;

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("timeout after %0d cycles in field %0d row %0d", cycles, fieldNum, scanRow);
			$display("Something failed");
			$finish;
		end
	end

	// counters follow the stated sequence from reset
	always @(posedge clock)
	begin
		if (rst)
		begin
			scanPhase = videoTimingPkg::vSync;
			scanPix = 0;
			scanRow = 0;
			halfLeft = videoTimingPkg::vSyncHalfLines;
			eqCount = videoTimingPkg::eqHalfLinesEven;
			fieldNum = 0;
		end
		else if (scanPhase != videoTimingPkg::scanLine)
		begin
			if (scanPix == videoTimingPkg::halfLineCycles - 1)
			begin
				scanPix = 0;
				if (halfLeft == 1)
				begin
					scanPhase = (scanPhase == videoTimingPkg::vSync) ?
						videoTimingPkg::eqPulse : videoTimingPkg::scanLine;
					halfLeft = eqCount;
				end
				else
					halfLeft = halfLeft - 1;
			end
			else
				scanPix = scanPix + 1;
		end
		else if (scanPix == videoTimingPkg::lineCycles - 1)
		begin
			scanPix = 0;
			if (scanRow == videoTimingPkg::fieldRows - 1)
			begin
				scanRow = 0;
				scanPhase = videoTimingPkg::vSync;
				halfLeft = videoTimingPkg::vSyncHalfLines;
				fieldNum = fieldNum + 1;
				eqCount = (fieldNum % 2 == 1) ? videoTimingPkg::eqHalfLinesOdd :
					videoTimingPkg::eqHalfLinesEven;
			end
			else
				scanRow = scanRow + 1;
		end
		else
			scanPix = scanPix + 1;
	end

	task automatic checkRange(input int t, input int lo, input int hi);
		checks[t]++;
		assert ((int'(pwmOut) >= lo) && (int'(pwmOut) <= hi))
		else
		begin
			fails[t]++;
			if (fails[t] <= errShown)
				$display("ERR pwmOut %s row %0d pix %0d: got %0h, expected %0h to %0h",
					testName[t], scanRow, scanPix, pwmOut, lo, hi);
		end
	endtask

	// pixel on screen left the scan counter pipeDelay clocks ago
	task automatic checkActive();
		int q;
		int idx;
		int t;
		int m;
		int n;
		int mn;
		int nm;
		bit ok;
		q = scanPix - pipeDelay;
		idx = ((scanRow - videoTimingPkg::firstActiveRow) / 4) * cellsPerRow +
			(q / 8 - videoTimingPkg::activeStart / 8) / 8;
		m = lumaM[idx];
		n = lumaN[idx];
		if (fillMode == 1)
		begin
			t = 3;
			ok = pwmFits(int'(pwmOut), m, m);
		end
		else
		begin
			t = 4;
			// blends floored per quarter may land one luma lower
			mn = (3 * m) / 4 + n / 4;
			nm = (3 * n) / 4 + m / 4;
			ok = pwmFits(int'(pwmOut), m, m) || pwmFits(int'(pwmOut), n, n) ||
				pwmFits(int'(pwmOut), (mn > 0) ? mn - 1 : 0, mn) ||
				pwmFits(int'(pwmOut), (nm > 0) ? nm - 1 : 0, nm);
		end
		checks[t]++;
		assert (ok)
		else
		begin
			fails[t]++;
			if (fails[t] <= errShown)
				$display("ERR pwmOut row %0d pix %0d: got %0h, cell %0d lumas %0h %0h",
					scanRow, scanPix, pwmOut, idx, m, n);
		end
	endtask

	// windows sit inside each region by more than the pipeline delay
	task automatic checkSample();
		case (scanPhase)
			videoTimingPkg::vSync:
				if ((scanPix >= 480) && (scanPix <= 3170))
					checkRange(timingTest(0), 0, 0);
			videoTimingPkg::eqPulse:
				if ((scanPix >= 2952) && (scanPix <= 3170))
					checkRange(timingTest(0), 0, 0);
			default:
			begin
				if ((scanPix >= 5888) && (scanPix <= 6340))
					checkRange(timingTest(0), 0, 0);
				else if ((scanPix >= 5600) && (scanPix <= 5870))
					checkRange(timingTest(1), blankLo, blankHi);
				else if ((scanPix >= 120) && (scanPix <= 350))
					checkRange(timingTest(2), burstLo, burstHi);
				else if ((scanRow < videoTimingPkg::firstActiveRow) && (scanPix >= 480) &&
					(scanPix <= 5580))
					checkRange(timingTest(1), blankLo, blankHi);
				else if ((scanRow >= videoTimingPkg::firstActiveRow) &&
					(scanRow < videoTimingPkg::firstActiveRow + 240) &&
					(scanPix >= 600) && (scanPix <= 5500) && (fillMode != 0))
					checkActive();
			end
		endcase
	endtask

	always @(negedge clock)
	begin
		if (!rst && (fieldNum < 2))
			checkSample();
	end

	task automatic writeWord(input int addr, input logic [31:0] data);
		fbWrite.enable = 1'b1;
		fbWrite.wordAddr = 14'(addr);
		fbWrite.data = data;
		@(negedge clock);
		fbWrite.enable = 1'b0;
	endtask

	// centroid cells, zero delta, chroma 64 shifted to 128
	task automatic fillGray();
		logic [7:0] luma;
		for (int i = 0; i < cellCount; i++)
		begin
			rngState = xorshift(rngState);
			luma = rngState[7:0];
			lumaM[i] = int'(luma);
			lumaN[i] = int'(luma);
			writeWord(2 * i, {2'b11, 7'h40, 7'h40, luma, 8'h00});
			writeWord(2 * i + 1, 32'h0);
		end
	endtask

	// pair cells, chroma nibbles 8, random selectors
	task automatic fillPair();
		logic [6:0] m7;
		logic [6:0] n7;
		for (int i = 0; i < cellCount; i++)
		begin
			rngState = xorshift(rngState);
			m7 = rngState[6:0];
			n7 = rngState[14:8];
			lumaM[i] = int'({m7, m7[6]});
			lumaN[i] = int'({n7, n7[6]});
			writeWord(2 * i, {2'b10, m7, n7, 16'h8888});
			rngState = xorshift(rngState);
			writeWord(2 * i + 1, rngState);
		end
	endtask

	task automatic reportTest(input int t);
		if (checks[t] == 0)
		begin
			fails[t]++;
			$display("%s: never reached, counted as failed", testName[t]);
		end
		else
			$display("%s: %0d checks, %0d failed", testName[t], checks[t], fails[t]);
	endtask

	initial
	begin
		int totalChecks;
		int totalFails;
		clock = 1'b0;
		rst = 1'b1;
		fbWrite = '0;
		cycles = 0;
		fillMode = 0;
		rngState = 32'h6aa;
		for (int t = 0; t < 6; t++)
		begin
			checks[t] = 0;
			fails[t] = 0;
		end
		repeat (10) @(negedge clock);
		rst = 1'b0;
		// fill lands in the vertical interval of field 0
		fillGray();
		fillMode = 1;
		wait (fieldNum == 1);
		@(negedge clock);
		for (int t = 0; t < 4; t++)
			reportTest(t);
		fillMode = 0;
		fillPair();
		fillMode = 2;
		wait (fieldNum == 2);
		@(negedge clock);
		reportTest(4);
		reportTest(5);
		totalChecks = 0;
		totalFails = 0;
		for (int t = 0; t < 6; t++)
		begin
			totalChecks += checks[t];
			totalFails += fails[t];
		end
		$display("6 tests, %0d checks, %0d failures", totalChecks, totalFails);
		if (totalFails == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/videoTimingPkg.sv
common/cellFormatPkg.sv
timing/scanTiming.sv
cell/frameStore.sv
cell/cellDecode.sv
logic/compositeEncoder.sv
logic/fbNtsc.sv
dv/fbNtsc_assert.sv
dv/fbNtscTb.sv

// File: Makefile
# Verilator build and run of the composite video testbench

VERILATOR ?= verilator
TOP ?= fbNtscTb
FILELIST ?= filelist.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
